// ==== verilog/mem_access_pkg.sv ====
/* Access sizes, data types and the request/response words that pass between the
   requester lanes, the arbiter and the bus manager */
`default_nettype none

package mem_access_pkg;

    // Encoding matches the core's load/store unit
    typedef enum logic [1:0] {
        SIZE_BYTE     = 2'b00,
        SIZE_HALFWORD = 2'b01,
        SIZE_WORD     = 2'b10
    } size_e;

    typedef logic [31:0] paddr_t; // Byte address
    typedef logic [31:0] word_t;  // One bus word
    typedef logic [3:0]  strb_t;  // One enable per byte lane

    // Request as the bus sees it
    typedef struct packed {
        logic   wen;   // 1 for store
        paddr_t addr;  // Word aligned
        strb_t  strb;  // Bytes touched by a store
        word_t  wdata; // Sub-word data copied into every lane
    } lane_req_t;

    // Completion as returned by the manager
    typedef struct packed {
        logic  done;  // Single-cycle pulse
        word_t rdata; // Raw word, lane picks its field
        logic  error; // Any response other than OKAY
    } bus_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/axi_lite_pkg.sv ====
/* AXI4-Lite channel bundles and response codes for the outside bus.
   The manager drives axi_mreq_t and the subordinate answers with axi_srsp_t */
`default_nettype none

package axi_lite_pkg;

    localparam int ID_W   = 4;
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    localparam logic [1:0] BURST_FIXED = 2'b00; // No address increment
    localparam logic [2:0] AXSIZE_4B   = 3'b010; // Full 32 bit beats only

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    // Manager to subordinate
    typedef struct packed {
        logic              awvalid;
        logic [ID_W-1:0]   awid;
        logic [ADDR_W-1:0] awaddr;
        logic [7:0]        awlen;   // Beats minus one
        logic [2:0]        awsize;
        logic [1:0]        awburst;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic              bready;
        logic              arvalid;
        logic [ID_W-1:0]   arid;
        logic [ADDR_W-1:0] araddr;
        logic [7:0]        arlen;
        logic [2:0]        arsize;
        logic [1:0]        arburst;
        logic              rready;
    } axi_mreq_t;

    // Subordinate to manager
    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              arready;
        logic              bvalid;
        logic [ID_W-1:0]   bid;
        resp_e             bresp;
        logic              rvalid;
        logic [ID_W-1:0]   rid;
        logic [DATA_W-1:0] rdata;
        resp_e             rresp;
    } axi_srsp_t;

endpackage

`default_nettype wire

// ==== verilog/req_lane.sv ====
/* Per-requester lane that turns a load/store into a bus word request and
   registers the completion, error and zero-extended load result */
`timescale 1ns/1ps
`default_nettype none

module req_lane (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_valid,
    input  wire                         i_wen,
    input  mem_access_pkg::size_e       i_size,
    input  mem_access_pkg::paddr_t      i_addr,
    input  mem_access_pkg::word_t       i_wdata,
    input  wire                         i_grant,
    input  mem_access_pkg::bus_rsp_t    i_rsp,
    output logic                        o_req_valid,
    output mem_access_pkg::lane_req_t   o_req,
    output logic                        o_ready,
    output mem_access_pkg::word_t       o_rdata,
    output logic                        o_error
);

    mem_access_pkg::strb_t strb;
    mem_access_pkg::word_t wdata_rep;
    mem_access_pkg::word_t load_data;
    logic                  take;      // Shared completion is ours

    always_comb begin
        case (i_size)
            mem_access_pkg::SIZE_BYTE: begin
                strb      = 4'b0001 << i_addr[1:0];
                wdata_rep = {4{i_wdata[7:0]}};   // Byte lands in whichever lane is enabled
            end
            mem_access_pkg::SIZE_HALFWORD: begin
                strb      = i_addr[1] ? 4'b1100 : 4'b0011;
                wdata_rep = {2{i_wdata[15:0]}};
            end
            default: begin
                strb      = 4'b1111;
                wdata_rep = i_wdata;
            end
        endcase
    end

    assign o_req = '{wen: i_wen, addr: {i_addr[31:2], 2'b00}, strb: strb, wdata: wdata_rep};

    // Hidden while o_ready is up so the arbiter cannot grant the finished access again
    assign o_req_valid = i_valid & ~o_ready;

    // Field select from the raw word, zero extended
    always_comb begin
        case (i_size)
            mem_access_pkg::SIZE_BYTE:     load_data = {24'b0, i_rsp.rdata[8*i_addr[1:0] +: 8]};
            mem_access_pkg::SIZE_HALFWORD: load_data = {16'b0, i_rsp.rdata[16*i_addr[1] +: 16]};
            default:                       load_data = i_rsp.rdata;
        endcase
    end

    assign take = i_rsp.done & i_grant;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ready <= 1'b0;
            o_error <= 1'b0;
        end else begin
            o_ready <= take;                 // One-cycle pulse after done
            o_error <= take & i_rsp.error;
        end
    end

    // Load result stays put until the next load completes
    always_ff @(posedge i_clk) begin
        if (take && !i_wen) o_rdata <= load_data;
    end

endmodule

`default_nettype wire

// ==== verilog/rr_arbiter.sv ====
/* Round-robin arbiter over the lanes. The grant is registered, held until the
   manager reports done, and selects which lane request goes to the bus */
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
    parameter int NUM_REQUESTERS = 3
) (
    input  wire                                             i_clk,
    input  wire                                             i_rst_n,
    input  wire  [NUM_REQUESTERS-1:0]                       i_valid,
    input  mem_access_pkg::lane_req_t [NUM_REQUESTERS-1:0]  i_req,
    input  wire                                             i_done,
    output logic [NUM_REQUESTERS-1:0]                       o_grant,
    output logic                                            o_valid,
    output mem_access_pkg::lane_req_t                       o_req
);

    localparam int IDX_W = (NUM_REQUESTERS > 1) ? $clog2(NUM_REQUESTERS) : 1;

    logic [IDX_W-1:0]          last_q;    // Lane granted most recently
    logic [IDX_W-1:0]          pick_idx;
    logic [NUM_REQUESTERS-1:0] pick_oh;
    logic                      found;

    // First valid lane after last_q, wrapping
    always_comb begin
        int unsigned idx;
        pick_idx = last_q;
        pick_oh  = '0;
        found    = 1'b0;
        for (int k = 1; k <= NUM_REQUESTERS; k++) begin
            idx = int'(last_q) + k;
            if (idx >= NUM_REQUESTERS) idx = idx - NUM_REQUESTERS;
            if (!found && i_valid[idx]) begin
                found        = 1'b1;
                pick_idx     = IDX_W'(idx);
                pick_oh[idx] = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_grant <= '0;
            last_q  <= IDX_W'(NUM_REQUESTERS - 1); // First search starts at lane 0
        end else if (o_grant == '0) begin
            if (found) begin
                o_grant <= pick_oh;
                last_q  <= pick_idx;
            end
        end else if (i_done) begin
            o_grant <= '0;                         // Lane sees done on this same edge
        end
    end

    assign o_valid = |o_grant;
    assign o_req   = i_req[last_q];                // last_q always names the held lane

endmodule

`default_nettype wire

// ==== verilog/axi_lite_manager.sv ====
/* AXI4-Lite manager FSM that runs one single-beat read or write per request
   and returns the raw read word with a done pulse and an error flag */
`timescale 1ns/1ps
`default_nettype none

module axi_lite_manager #(
    parameter int AXI_ID = 0
) (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_valid,
    input  mem_access_pkg::lane_req_t     i_req,
    input  axi_lite_pkg::axi_srsp_t       i_axi,
    output axi_lite_pkg::axi_mreq_t       o_axi,
    output mem_access_pkg::bus_rsp_t      o_rsp
);

    // Mealy FSM
    typedef enum logic [2:0] {
        IDLE,
        SEND_RADDR,
        GET_RDATA,
        SEND_WADDR,
        SEND_WDATA,
        GET_BRESP
    } state_e;

    state_e state, next_state;

    logic aw_valid;
    logic w_valid;
    logic ar_valid;
    logic r_ready;
    logic done;
    logic err;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) state <= IDLE;
        else          state <= next_state;
    end

    always_comb begin
        next_state = state;
        aw_valid   = 1'b0;
        w_valid    = 1'b0;
        ar_valid   = 1'b0;
        r_ready    = 1'b0;
        done       = 1'b0;
        err        = 1'b0;
        case (state)
            IDLE: begin
                if (i_valid) begin
                    if (i_req.wen) begin
                        aw_valid = 1'b1;           // Address and data offered together
                        w_valid  = 1'b1;
                        if (i_axi.awready && i_axi.wready) next_state = GET_BRESP;
                        else if (i_axi.awready)            next_state = SEND_WDATA;
                        else if (i_axi.wready)             next_state = SEND_WADDR;
                    end else begin
                        ar_valid   = 1'b1;
                        next_state = i_axi.arready ? GET_RDATA : SEND_RADDR;
                    end
                end
            end
            SEND_RADDR: begin
                ar_valid = 1'b1;
                if (i_axi.arready) next_state = GET_RDATA;
            end
            GET_RDATA: begin
                r_ready = 1'b1;
                if (i_axi.rvalid) begin
                    done       = 1'b1;
                    err        = (i_axi.rresp != axi_lite_pkg::RESP_OKAY);
                    next_state = IDLE;
                end
            end
            SEND_WADDR: begin
                aw_valid = 1'b1;                   // Data already accepted
                if (i_axi.awready) next_state = GET_BRESP;
            end
            SEND_WDATA: begin
                w_valid = 1'b1;
                if (i_axi.wready) next_state = GET_BRESP;
            end
            GET_BRESP: begin
                if (i_axi.bvalid) begin            // bready is tied high
                    done       = 1'b1;
                    err        = (i_axi.bresp != axi_lite_pkg::RESP_OKAY);
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_comb begin
        o_axi = '0;

        o_axi.awvalid = aw_valid;
        o_axi.awid    = axi_lite_pkg::ID_W'(AXI_ID);   // Single fixed ID
        o_axi.awaddr  = i_req.addr;                    // Aligned by the lane
        o_axi.awlen   = 8'd0;                          // One beat
        o_axi.awsize  = axi_lite_pkg::AXSIZE_4B;
        o_axi.awburst = axi_lite_pkg::BURST_FIXED;

        o_axi.wvalid  = w_valid;
        o_axi.wdata   = i_req.wdata;
        o_axi.wstrb   = i_req.strb;                    // Sub-word stores via strobes
        o_axi.bready  = 1'b1;

        o_axi.arvalid = ar_valid;
        o_axi.arid    = axi_lite_pkg::ID_W'(AXI_ID);
        o_axi.araddr  = i_req.addr;
        o_axi.arlen   = 8'd0;
        o_axi.arsize  = axi_lite_pkg::AXSIZE_4B;
        o_axi.arburst = axi_lite_pkg::BURST_FIXED;
        o_axi.rready  = r_ready;
    end

    // Raw word goes back untouched, field select happens in the lane
    assign o_rsp = '{done: done, rdata: i_axi.rdata, error: err};

endmodule

`default_nettype wire

// ==== verilog/core_mem_port.sv ====
/* Core memory port top level. Per-requester lanes share one AXI4-Lite
   manager through a round-robin arbiter */
`timescale 1ns/1ps
`default_nettype none

module core_mem_port #(
    parameter int NUM_REQUESTERS = 3, // Page walker, I-cache and D-cache
    parameter int AXI_ID         = 0
) (
    input  wire                                             i_clk,
    input  wire                                             i_rst_n,
    input  wire  [NUM_REQUESTERS-1:0]                       i_valid,
    input  wire  [NUM_REQUESTERS-1:0]                       i_wen,
    input  mem_access_pkg::size_e  [NUM_REQUESTERS-1:0]     i_size,
    input  mem_access_pkg::paddr_t [NUM_REQUESTERS-1:0]     i_addr,
    input  mem_access_pkg::word_t  [NUM_REQUESTERS-1:0]     i_wdata,
    output logic [NUM_REQUESTERS-1:0]                       o_ready,
    output mem_access_pkg::word_t  [NUM_REQUESTERS-1:0]     o_rdata,
    output logic [NUM_REQUESTERS-1:0]                       o_error,
    input  axi_lite_pkg::axi_srsp_t                         i_axi,
    output axi_lite_pkg::axi_mreq_t                         o_axi
);

    logic [NUM_REQUESTERS-1:0]                      lane_valid;
    mem_access_pkg::lane_req_t [NUM_REQUESTERS-1:0] lane_req;
    logic [NUM_REQUESTERS-1:0]                      grant;
    logic                                           bus_valid;
    mem_access_pkg::lane_req_t                      bus_req;
    mem_access_pkg::bus_rsp_t                       bus_rsp;   // Broadcast to every lane

    for (genvar g = 0; g < NUM_REQUESTERS; g++) begin : g_lane
        req_lane u_lane (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_valid     (i_valid[g]),
            .i_wen       (i_wen[g]),
            .i_size      (i_size[g]),
            .i_addr      (i_addr[g]),
            .i_wdata     (i_wdata[g]),
            .i_grant     (grant[g]),
            .i_rsp       (bus_rsp),
            .o_req_valid (lane_valid[g]),
            .o_req       (lane_req[g]),
            .o_ready     (o_ready[g]),
            .o_rdata     (o_rdata[g]),
            .o_error     (o_error[g])
        );
    end

    rr_arbiter #(.NUM_REQUESTERS(NUM_REQUESTERS)) u_arb (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_valid (lane_valid), .i_req (lane_req), .i_done (bus_rsp.done),
        .o_grant (grant), .o_valid (bus_valid), .o_req (bus_req)
    );

    axi_lite_manager #(.AXI_ID(AXI_ID)) u_mgr (
        .i_clk (i_clk), .i_rst_n (i_rst_n),
        .i_valid (bus_valid), .i_req (bus_req), .i_axi (i_axi),
        .o_axi (o_axi), .o_rsp (bus_rsp)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
/* Free-running clock for the testbench, period set by parameter */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk; // 50 % duty
    end

endmodule

`default_nettype wire

// ==== verification/axi_mem_model.sv ====
/* AXI4-Lite subordinate memory for the testbench. Stalls come from i_stall,
   and the top 256 bytes of the address space answer SLVERR and ignore writes */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
    input  wire                       i_clk,
    input  wire                       i_rst_n,
    input  wire  [7:0]                i_stall,  // Fresh random bits every cycle
    input  axi_lite_pkg::axi_mreq_t   i_req,
    output axi_lite_pkg::axi_srsp_t   o_rsp
);

    logic [31:0] mem [1024];      // 4 KB, higher addresses alias onto it

    logic        aw_got;          // Write address latched
    logic        w_got;           // Write data latched
    logic        b_pend;
    logic        r_pend;
    logic [1:0]  b_cnt;           // Response delay countdowns
    logic [1:0]  r_cnt;
    logic [31:0] aw_addr;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic [31:0] r_addr;
    logic [3:0]  aw_id;
    logic [3:0]  r_id;
    logic        aw_rdy;
    logic        w_rdy;
    logic        ar_rdy;

    function automatic logic in_err(input logic [31:0] addr);
        return &addr[31:8];       // Top 256 bytes
    endfunction

    // Power-on contents, a function of the full word index
    initial begin
        for (int i = 0; i < 1024; i++) mem[i] = 32'h9e37_79b9 * (i + 1);
    end

    assign aw_rdy = !aw_got && !b_pend && i_stall[0];
    assign w_rdy  = !w_got && !b_pend && i_stall[1];
    assign ar_rdy = !r_pend && i_stall[2];

    always_comb begin
        o_rsp         = '0;
        o_rsp.awready = aw_rdy;
        o_rsp.wready  = w_rdy;
        o_rsp.arready = ar_rdy;
        o_rsp.bvalid  = b_pend && (b_cnt == 2'd0);
        o_rsp.bid     = aw_id;
        o_rsp.bresp   = in_err(aw_addr) ? axi_lite_pkg::RESP_SLVERR : axi_lite_pkg::RESP_OKAY;
        o_rsp.rvalid  = r_pend && (r_cnt == 2'd0);
        o_rsp.rid     = r_id;
        o_rsp.rdata   = in_err(r_addr) ? 32'h0 : mem[r_addr[11:2]];
        o_rsp.rresp   = in_err(r_addr) ? axi_lite_pkg::RESP_SLVERR : axi_lite_pkg::RESP_OKAY;
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_pend  <= 1'b0;
            r_pend  <= 1'b0;
            b_cnt   <= 2'd0;
            r_cnt   <= 2'd0;
            aw_addr <= '0;
            w_data  <= '0;
            w_strb  <= '0;
            r_addr  <= '0;
            aw_id   <= '0;
            r_id    <= '0;
        end else begin
            if (i_req.awvalid && aw_rdy) begin
                aw_got  <= 1'b1;
                aw_addr <= i_req.awaddr;
                aw_id   <= i_req.awid;
            end
            if (i_req.wvalid && w_rdy) begin
                w_got  <= 1'b1;
                w_data <= i_req.wdata;
                w_strb <= i_req.wstrb;
            end
            if (aw_got && w_got) begin              // Both halves in, commit and respond
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_pend <= 1'b1;
                b_cnt  <= i_stall[4:3];
            end else if (b_pend && b_cnt != 2'd0) begin
                b_cnt <= b_cnt - 2'd1;
            end else if (b_pend && i_req.bready) begin
                b_pend <= 1'b0;
            end
            if (i_req.arvalid && ar_rdy) begin
                r_pend <= 1'b1;
                r_cnt  <= i_stall[6:5];
                r_addr <= i_req.araddr;
                r_id   <= i_req.arid;
            end else if (r_pend && r_cnt != 2'd0) begin
                r_cnt <= r_cnt - 2'd1;
            end else if (r_pend && i_req.rready) begin
                r_pend <= 1'b0;
            end
        end
    end

    // Strobed write, dropped in the error region
    always @(posedge i_clk) begin
        if (aw_got && w_got && !in_err(aw_addr)) begin
            for (int b = 0; b < 4; b++) begin
                if (w_strb[b]) mem[aw_addr[11:2]][8*b +: 8] <= w_data[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_core_mem_port.sv ====
/* Testbench for the core memory port. Directed and random loads and stores from
   all requesters, checked against a shadow memory, with round-robin and error checks */
`timescale 1ns/1ps
`default_nettype none

module tb_core_mem_port;

    localparam int          N       = 3;
    localparam int          TIMEOUT = 200;           // Cycles per access
    localparam logic [31:0] SEED    = 32'h0bca_cc1e;

    typedef struct packed {
        logic                   wen;
        mem_access_pkg::size_e  size;
        mem_access_pkg::paddr_t addr;
        mem_access_pkg::word_t  wdata;
    } access_t;

    logic                                clk;
    logic                                rst_n;
    logic [N-1:0]                        valid;
    logic [N-1:0]                        wen;
    mem_access_pkg::size_e  [N-1:0]      size;
    mem_access_pkg::paddr_t [N-1:0]      addr;
    mem_access_pkg::word_t  [N-1:0]      wdata;
    logic [N-1:0]                        ready;
    mem_access_pkg::word_t  [N-1:0]      rdata;
    logic [N-1:0]                        error;
    axi_lite_pkg::axi_mreq_t             axi_req;
    axi_lite_pkg::axi_srsp_t             axi_rsp;
    logic [7:0]                          stall;

    mem_access_pkg::word_t shadow [1024];   // Expected memory contents
    access_t               cur_op [N];      // Access each requester is presenting
    logic [N-1:0]          pending;
    logic [31:0]           seed_q [N];      // One random stream per requester
    logic [31:0]           stall_seed;
    int                    done_order[$];   // Requester index per completion
    mem_access_pkg::strb_t last_wstrb;      // Strobes of the latest accepted W beat

    tb_clk_gen #(.PERIOD_NS(40)) u_clk (.o_clk(clk));

    core_mem_port #(.NUM_REQUESTERS(N), .AXI_ID(0)) dut (
        .i_clk (clk), .i_rst_n (rst_n),
        .i_valid (valid), .i_wen (wen), .i_size (size), .i_addr (addr), .i_wdata (wdata),
        .o_ready (ready), .o_rdata (rdata), .o_error (error),
        .i_axi (axi_rsp), .o_axi (axi_req)
    );

    axi_mem_model u_mem (
        .i_clk (clk), .i_rst_n (rst_n), .i_stall (stall), .i_req (axi_req), .o_rsp (axi_rsp)
    );

    function automatic logic [31:0] lcg_next(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_word(input string name, input mem_access_pkg::word_t got,
                              input mem_access_pkg::word_t exp);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_size(input string name, input mem_access_pkg::size_e got,
                              input mem_access_pkg::size_e exp);
        if (got !== exp)
            fail_now($sformatf("mismatch at %0t: %s got %s expected %s", $time, name,
                               got.name(), exp.name()));
    endtask

    // Store size implied by how many byte lanes the strobes enable
    function automatic mem_access_pkg::size_e size_of_strb(input mem_access_pkg::strb_t s);
        case ($countones(s))
            1:       return mem_access_pkg::SIZE_BYTE;
            2:       return mem_access_pkg::SIZE_HALFWORD;
            4:       return mem_access_pkg::SIZE_WORD;
            default: return mem_access_pkg::size_e'(2'b11);  // No legal size
        endcase
    endfunction

    // Applies a store to the shadow memory, returns the expected zero-extended load
    function automatic mem_access_pkg::word_t expect_access(input access_t a, output logic exp_err);
        mem_access_pkg::word_t w;
        mem_access_pkg::word_t result;
        int unsigned           sh;
        exp_err = &a.addr[31:8];
        w       = shadow[a.addr[11:2]];
        sh      = 8 * a.addr[1:0];
        result  = '0;
        if (exp_err) return result;                // Nothing stored, data undefined
        if (a.wen) begin
            case (a.size)
                mem_access_pkg::SIZE_BYTE:     w[sh +: 8]  = a.wdata[7:0];
                mem_access_pkg::SIZE_HALFWORD: w[sh +: 16] = a.wdata[15:0];
                default:                       w           = a.wdata;
            endcase
            shadow[a.addr[11:2]] = w;
        end else begin
            case (a.size)
                mem_access_pkg::SIZE_BYTE:     result = {24'h0, w[sh +: 8]};
                mem_access_pkg::SIZE_HALFWORD: result = {16'h0, w[sh +: 16]};
                default:                       result = w;
            endcase
        end
        return result;
    endfunction

    function automatic access_t rand_access(input int r);
        access_t     a;
        logic [31:0] v;
        v      = lcg_next(seed_q[r]);
        a.wen  = v[31];
        case (v[30:29])
            2'd0:    a.size = mem_access_pkg::SIZE_BYTE;
            2'd1:    a.size = mem_access_pkg::SIZE_HALFWORD;
            default: a.size = mem_access_pkg::SIZE_WORD;
        endcase
        a.addr = {24'h0, v[27:20]};                // Small window, lots of overlap
        if (a.size == mem_access_pkg::SIZE_HALFWORD) a.addr[0] = 1'b0;
        if (a.size == mem_access_pkg::SIZE_WORD)     a.addr[1:0] = 2'b00;
        if (v[28] && v[19:17] == 3'b000) a.addr[31:8] = '1;   // Rare error-region hit
        a.wdata = lcg_next(seed_q[r]);
        return a;
    endfunction

    // Presents one access and waits for its o_ready, entered 2 ns after a rising edge
    task automatic do_access(input int r, input access_t a);
        int waited;
        cur_op[r]  = a;
        pending[r] = 1'b1;
        valid[r]   = 1'b1;
        wen[r]     = a.wen;
        size[r]    = a.size;
        addr[r]    = a.addr;
        wdata[r]   = a.wdata;
        waited     = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
            if (waited > TIMEOUT)
                fail_now($sformatf("timeout: requester %0d saw no o_ready in %0d cycles",
                                   r, TIMEOUT));
        end while (!ready[r]);
        pending[r] = 1'b0;
    endtask

    task automatic one_access(input int r, input logic w, input mem_access_pkg::size_e s,
                              input mem_access_pkg::paddr_t a, input mem_access_pkg::word_t d);
        access_t op;
        op = '{wen: w, size: s, addr: a, wdata: d};
        do_access(r, op);
        valid[r] = 1'b0;
    endtask

    task automatic run_random(input int r, input int count);
        logic [31:0] v;
        for (int i = 0; i < count; i++) begin
            do_access(r, rand_access(r));
            v = lcg_next(seed_q[r]);
            if (v[17:16] != 2'd0) begin            // Idle gap of up to 3 cycles
                valid[r] = 1'b0;
                repeat (v[17:16]) begin
                    @(posedge clk);
                    #2;
                end
            end
        end
        valid[r] = 1'b0;
    endtask

    task automatic run_burst(input int r, input int count);
        for (int i = 0; i < count; i++) do_access(r, rand_access(r));  // i_valid never drops
        valid[r] = 1'b0;
    endtask

    task automatic check_rr_order(input int total);
        if (done_order.size() != total)
            fail_now($sformatf("round-robin phase saw %0d completions instead of %0d",
                               done_order.size(), total));
        for (int i = 1; i < total; i++) begin
            if (done_order[i] != (done_order[0] + i) % N)
                fail_now($sformatf("mismatch at %0t: completion %0d requester got %0d expected %0d",
                                   $time, i, done_order[i], (done_order[0] + i) % N));
        end
    endtask

    // Random stall bits for the memory model
    initial begin : stall_proc
        logic [31:0] v;
        forever begin
            @(posedge clk);
            #2;
            v     = lcg_next(stall_seed);
            stall = v[23:16];
        end
    end

    // Bus fields sampled mid-cycle, where they are stable
    always @(negedge clk) begin
        if (axi_req.wvalid && axi_rsp.wready) last_wstrb = axi_req.wstrb;
        check_flag("o_axi.bready", axi_req.bready, 1'b1);
        // Single beat, ID 0, 4-byte size, FIXED burst
        if (axi_req.awvalid)
            check_word("o_axi.{awid,awlen,awsize,awburst}",
                       32'({axi_req.awid, axi_req.awlen, axi_req.awsize, axi_req.awburst}),
                       {15'h0, 4'h0, 8'h00, 3'b010, 2'b00});
        if (axi_req.arvalid)
            check_word("o_axi.{arid,arlen,arsize,arburst}",
                       32'({axi_req.arid, axi_req.arlen, axi_req.arsize, axi_req.arburst}),
                       {15'h0, 4'h0, 8'h00, 3'b010, 2'b00});
    end

    // Checks every completion against the shadow memory, 1 ns after the edge
    initial begin : compare_proc
        access_t               op;
        mem_access_pkg::word_t exp_data;
        logic                  exp_err;
        forever begin
            @(posedge clk);
            #1;
            for (int r = 0; r < N; r++) begin
                if (ready[r]) begin
                    if (!pending[r])
                        fail_now($sformatf("requester %0d got o_ready with no access pending", r));
                    op = cur_op[r];
                    if (op.wen)                    // Last W beat on the bus was this store
                        check_size($sformatf("o_axi.wstrb size for requester %0d", r),
                                   size_of_strb(last_wstrb), op.size);
                    exp_data = expect_access(op, exp_err);
                    check_flag($sformatf("o_error[%0d]", r), error[r], exp_err);
                    if (!op.wen && !exp_err)
                        check_word($sformatf("o_rdata[%0d]", r), rdata[r], exp_data);
                    done_order.push_back(r);
                end
            end
        end
    end

    initial begin : main_proc
        rst_n      = 1'b0;
        valid      = '0;
        wen        = '0;
        pending    = '0;
        stall      = '0;
        last_wstrb = '0;
        stall_seed = SEED;
        for (int r = 0; r < N; r++) begin
            size[r]   = mem_access_pkg::SIZE_WORD;
            addr[r]   = '0;
            wdata[r]  = '0;
            cur_op[r] = '0;
            seed_q[r] = SEED + 32'h1000_0000 * (r + 1);
        end
        for (int i = 0; i < 1024; i++) shadow[i] = 32'h9e37_79b9 * (i + 1);  // Model's fill
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Quiet after reset
        repeat (10) begin
            @(posedge clk);
            #2;
            check_flag("any o_ready", |ready, 1'b0);
            check_flag("o_axi.awvalid", axi_req.awvalid, 1'b0);
            check_flag("o_axi.wvalid", axi_req.wvalid, 1'b0);
            check_flag("o_axi.arvalid", axi_req.arvalid, 1'b0);
        end

        // Word written by one requester, read back by another
        one_access(0, 1'b1, mem_access_pkg::SIZE_WORD, 32'h40, 32'hcafe_f00d);
        one_access(1, 1'b0, mem_access_pkg::SIZE_WORD, 32'h40, '0);
        check_word("o_rdata[1]", rdata[1], 32'hcafe_f00d);

        // Sub-word stores at every offset, junk in the unused upper bits
        for (int off = 0; off < 4; off++) begin
            one_access(off % N, 1'b1, mem_access_pkg::SIZE_BYTE, 32'h80 + off,
                       32'hdead_be00 | (off * 32'h11));
            one_access((off + 1) % N, 1'b0, mem_access_pkg::SIZE_WORD, 32'h80, '0);
        end
        for (int off = 0; off < 4; off += 2) begin
            one_access(2, 1'b1, mem_access_pkg::SIZE_HALFWORD, 32'h84 + off, 32'hffff_8000 + off);
            one_access(0, 1'b0, mem_access_pkg::SIZE_WORD, 32'h84, '0);
        end
        for (int off = 0; off < 4; off++) begin
            one_access(off % N, 1'b0, mem_access_pkg::SIZE_BYTE, 32'h80 + off, '0);
            one_access(1, 1'b0, mem_access_pkg::SIZE_HALFWORD, 32'h84 + (off & 2), '0);
        end

        // All requesters at once under random stalls
        fork
            run_random(0, 40);
            run_random(1, 40);
            run_random(2, 40);
        join

        // Every requester holds i_valid, completions must rotate
        done_order.delete();
        fork
            run_burst(0, 6);
            run_burst(1, 6);
            run_burst(2, 6);
        join
        check_rr_order(3 * 6);

        // Error region, then the aliased words must be untouched
        one_access(2, 1'b1, mem_access_pkg::SIZE_WORD, 32'hffff_ff00, 32'h1234_5678);
        one_access(0, 1'b1, mem_access_pkg::SIZE_BYTE, 32'hffff_ff05, 32'h0000_00aa);
        one_access(1, 1'b1, mem_access_pkg::SIZE_HALFWORD, 32'hffff_fffe, 32'h0000_bbbb);
        one_access(2, 1'b0, mem_access_pkg::SIZE_WORD, 32'hffff_ff00, '0);
        one_access(0, 1'b0, mem_access_pkg::SIZE_BYTE, 32'hffff_ff05, '0);
        one_access(1, 1'b0, mem_access_pkg::SIZE_WORD, 32'h0000_0f00, '0);
        one_access(2, 1'b0, mem_access_pkg::SIZE_WORD, 32'h0000_0f04, '0);
        one_access(0, 1'b0, mem_access_pkg::SIZE_WORD, 32'h0000_0ffc, '0);

        repeat (4) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/mem_access_pkg.sv
verilog/axi_lite_pkg.sv
verilog/req_lane.sv
verilog/rr_arbiter.sv
verilog/axi_lite_manager.sv
verilog/core_mem_port.sv
verification/tb_clk_gen.sv
verification/axi_mem_model.sv
verification/tb_core_mem_port.sv

// ==== Bender.yml ====
package:
  name: core_mem_port

sources:
  # Packages first, then leaf modules, then the top level
  - verilog/mem_access_pkg.sv
  - verilog/axi_lite_pkg.sv
  - verilog/req_lane.sv
  - verilog/rr_arbiter.sv
  - verilog/axi_lite_manager.sv
  - verilog/core_mem_port.sv

  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/axi_mem_model.sv
      - verification/tb_core_mem_port.sv
